// File: all.f
pgcb_pkg.sv
pgcb_if.sv
pgcb_req_sync.sv
pgcb_fsm.sv
pgcb_dfx_ovr.sv
pgcb_unit.sv
pgcb_tb.sv

// File: pgcb_dfx_ovr.sv
/*
 * DFx override stage between the sequencer and the pins
 * Registered outputs with a bypass sequencer that powers the partition
 * up or down on fdfx_pgcb_ovr, pok delayed by UNGATE_TIMER cycles
 * Combinational scan muxes for sleep and isolation, plus pwrgate_active
 */

`timescale 1ns/1ns

module pgcb_dfx_ovr #(
   parameter int UNGATE_TIMER = 4         // Cycles from bypass power-up to pok
) (
   input  logic    clk,
   input  logic    rst_n,
   input  logic    fdfx_pgcb_bypass,      // Bypass the sequencer
   input  logic    fdfx_pgcb_ovr,         // 1 powers up, 0 powers down in bypass
   input  logic    fscan_mode,
   input  logic    fscan_isol_ctrl,
   input  logic    fscan_isol_lat_ctrl,
   input  logic    fscan_ret_ctrl,
   input  logic    pmc_pgcb_fet_en_b,
   pgcb_ctl_if.ovr ctl,
   output logic    pgcb_sleep,
   output logic    pgcb_isol_latchen,
   output logic    pgcb_isol_en_b,
   output logic    pgcb_force_rst_b,
   output logic    pgcb_pok,
   output logic    pgcb_pwrgate_active,
   output logic    pgcb_ip_fet_en_b
);

   localparam int UT_W = (UNGATE_TIMER < 1) ? 1 : $clog2(UNGATE_TIMER + 1);
   localparam logic [UT_W-1:0] UT_MAX = UT_W'(UNGATE_TIMER);

   logic            bypass_up;            // Bypass with power-up command
   logic [UT_W-1:0] ungate_cnt;           // Saturating pok delay
   logic            sleep_q;
   logic            isol_latchen_q;
   logic            isol_en_b_q;

   assign bypass_up = fdfx_pgcb_bypass && fdfx_pgcb_ovr;

   // Restarts whenever the power-up command goes away
   always_ff @(posedge clk) begin
      if (!rst_n || !bypass_up) begin
         ungate_cnt <= '0;
      end else if (ungate_cnt != UT_MAX) begin
         ungate_cnt <= ungate_cnt + 1'b1;
      end
   end

   // Output stage, follows the FSM one cycle late when not bypassed
   always_ff @(posedge clk) begin
      if (fdfx_pgcb_bypass) begin
         sleep_q          <= ~fdfx_pgcb_ovr;          // Gated values at once on ovr=0
         isol_latchen_q   <= ~fdfx_pgcb_ovr;
         isol_en_b_q      <= fdfx_pgcb_ovr;
         pgcb_force_rst_b <= fdfx_pgcb_ovr;
         pgcb_pok         <= bypass_up && (ungate_cnt == UT_MAX);
         pgcb_ip_fet_en_b <= ~fdfx_pgcb_ovr;
      end else begin
         sleep_q          <= ctl.sleep;
         isol_latchen_q   <= ctl.isol_latchen;
         isol_en_b_q      <= ctl.isol_en_b;
         pgcb_force_rst_b <= ctl.force_rst_b;
         pgcb_pok         <= ctl.pok;
         pgcb_ip_fet_en_b <= pmc_pgcb_fet_en_b;       // PMC owns the FET
      end
   end

   // Scan wins over both bypass and the sequencer
   assign pgcb_sleep        = fscan_mode ? fscan_ret_ctrl      : sleep_q;
   assign pgcb_isol_en_b    = fscan_mode ? fscan_isol_ctrl     : isol_en_b_q;
   assign pgcb_isol_latchen = fscan_mode ? fscan_isol_lat_ctrl : isol_latchen_q;

   // In bypass the flow counts as active until pok is back
   assign pgcb_pwrgate_active = fdfx_pgcb_bypass ? ~pgcb_pok : ctl.pwrgate_active;

endmodule

// File: pgcb_fsm.sv
/*
 * Power-gate sequencer
 * Down flow: pok, isolation, forced reset, sleep, PMC request
 * Up flow: PMC release, wake, de-isolate, pok and reset release
 * Counted steps last delay_cycles of their cfg code from the cycle the
 * step's output changes; PMC steps wait on the synchronized ack level
 */

`timescale 1ns/1ns

module pgcb_fsm #(
   parameter int DEF_PWRON         = 1,   // 1 resets powered on, 0 resets gated
   parameter int ISOLLATCH_NOSR_EN = 0    // Latch enable for pg_acc without retention
) (
   input  logic                        clk,
   input  logic                        rst_n,
   input  logic                        ip_pgcb_sleep_en,
   input  logic [pgcb_pkg::DLY_W-1:0]  cfg_tpokdown,
   input  logic [pgcb_pkg::DLY_W-1:0]  cfg_tisolate,
   input  logic [pgcb_pkg::DLY_W-1:0]  cfg_trstdown,
   input  logic [pgcb_pkg::DLY_W-1:0]  cfg_tsleepinactiv,
   input  logic [pgcb_pkg::DLY_W-1:0]  cfg_tdeisolate,
   input  logic [pgcb_pkg::DLY_W-1:0]  cfg_tpokup,
   pgcb_req_if.dst                     req,
   pgcb_ctl_if.fsm                     ctl,
   output logic                        pgcb_pmc_pg_req_b,
   output logic                        pgcb_ip_pg_rdy_ack_b,
   output logic                        pgcb_restore,
   output pgcb_pkg::pgcb_state_t       state
);

   localparam logic PWR_ON = (DEF_PWRON != 0);

   logic [pgcb_pkg::CNT_W-1:0] step_cnt;     // Cycles left in the current counted step
   logic                       step_done;    // Last cycle of a counted step
   logic                       latch_close;  // Isolation latches close on this flow
   logic                       rst_assert;   // Forced reset is part of this flow
   logic                       wake_req;     // Request released or PMC restore

   // Load value so the step spans exactly delay_cycles
   function automatic logic [pgcb_pkg::CNT_W-1:0] step_load(
      input logic [pgcb_pkg::DLY_W-1:0] code
   );
      step_load = pgcb_pkg::delay_cycles(code) - 1'b1;
   endfunction

   assign step_done = (step_cnt == '0);
   assign wake_req  = !req.req || req.restore;

   // Inaccessible and warm always latch, accessible only without retention
   assign latch_close = (req.pg_type == pgcb_pkg::pg_inacc) ||
                        (req.pg_type == pgcb_pkg::pg_warm)  ||
                        ((req.pg_type == pgcb_pkg::pg_acc) &&
                         (ISOLLATCH_NOSR_EN != 0) && !ip_pgcb_sleep_en);

   assign rst_assert = (req.pg_type != pgcb_pkg::pg_acc);

   // Kept combinational so fabric locks follow the state directly
   assign ctl.pwrgate_active = (state != pgcb_pkg::st_on);

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         state                <= PWR_ON ? pgcb_pkg::st_on : pgcb_pkg::st_off;
         step_cnt             <= '0;
         ctl.pok              <= PWR_ON;
         ctl.sleep            <= 1'b0;
         ctl.isol_en_b        <= PWR_ON;
         ctl.isol_latchen     <= 1'b0;
         ctl.force_rst_b      <= PWR_ON;
         pgcb_pmc_pg_req_b    <= PWR_ON;
         pgcb_ip_pg_rdy_ack_b <= PWR_ON;
         pgcb_restore         <= 1'b0;
      end else begin
         if (!step_done) begin
            step_cnt <= step_cnt - 1'b1;          // Overridden below when a step starts
         end

         case (state)
            pgcb_pkg::st_on: begin
               if (req.req) begin
                  state    <= pgcb_pkg::st_pok_dn;
                  ctl.pok  <= 1'b0;
                  step_cnt <= step_load(cfg_tpokdown);
               end
            end

            pgcb_pkg::st_pok_dn: begin
               if (step_done) begin
                  state            <= pgcb_pkg::st_isolate;
                  ctl.isol_en_b    <= 1'b0;
                  ctl.isol_latchen <= latch_close;
                  step_cnt         <= step_load(cfg_tisolate);
               end
            end

            pgcb_pkg::st_isolate: begin
               if (step_done) begin
                  state           <= pgcb_pkg::st_rst_dn;
                  ctl.force_rst_b <= !rst_assert;
                  // Accessible gating passes through in one cycle
                  step_cnt        <= rst_assert ? step_load(cfg_trstdown) : '0;
               end
            end

            pgcb_pkg::st_rst_dn: begin
               if (step_done) begin
                  state     <= pgcb_pkg::st_sleep;
                  ctl.sleep <= ip_pgcb_sleep_en;      // Retention only when enabled
               end
            end

            pgcb_pkg::st_sleep: begin
               state             <= pgcb_pkg::st_pmc_req;
               pgcb_pmc_pg_req_b <= 1'b0;
            end

            pgcb_pkg::st_pmc_req: begin
               if (req.pmc_ack) begin
                  state                <= pgcb_pkg::st_off;
                  pgcb_ip_pg_rdy_ack_b <= 1'b0;   // Partition is off
               end
            end

            pgcb_pkg::st_off: begin
               if (wake_req) begin
                  state             <= pgcb_pkg::st_pmc_rel;
                  pgcb_pmc_pg_req_b <= 1'b1;
                  pgcb_restore      <= req.restore;  // Flag a PMC started wake
               end
            end

            pgcb_pkg::st_pmc_rel: begin
               if (!req.pmc_ack) begin
                  state     <= pgcb_pkg::st_wake;
                  ctl.sleep <= 1'b0;
                  step_cnt  <= step_load(cfg_tsleepinactiv);
               end
            end

            pgcb_pkg::st_wake: begin
               if (step_done) begin
                  state            <= pgcb_pkg::st_deisol;
                  ctl.isol_en_b    <= 1'b1;
                  ctl.isol_latchen <= 1'b0;
                  step_cnt         <= step_load(cfg_tdeisolate);
               end
            end

            pgcb_pkg::st_deisol: begin
               if (step_done) begin
                  state           <= pgcb_pkg::st_pok_up;
                  ctl.force_rst_b <= 1'b1;
                  ctl.pok         <= 1'b1;
                  step_cnt        <= step_load(cfg_tpokup);
               end
            end

            pgcb_pkg::st_pok_up: begin
               if (step_done) begin
                  state                <= pgcb_pkg::st_on;
                  pgcb_ip_pg_rdy_ack_b <= 1'b1;   // Fully up, ack returns high
                  pgcb_restore         <= 1'b0;
               end
            end

            // Unused codes fall back to the reset state
            default: begin
               state <= PWR_ON ? pgcb_pkg::st_on : pgcb_pkg::st_off;
            end
         endcase
      end
   end

endmodule

// File: pgcb_if.sv
/*
 * Internal connection bundles
 *   pgcb_req_if  synchronized handshake levels and captured type,
 *                request side to sequencer
 *   pgcb_ctl_if  sequencer gating controls, sequencer to DFx override
 */

`timescale 1ns/1ns

interface pgcb_req_if;

   logic                  req;          // IP gating request, active high
   logic                  pmc_ack;      // PMC acknowledge, active high
   logic                  restore;      // PMC restore request, active high
   pgcb_pkg::pg_type_t    pg_type;      // Type latched at the start of a request

   modport src (
      output req, pmc_ack, restore, pg_type
   );

   modport dst (
      input  req, pmc_ack, restore, pg_type
   );

endinterface

interface pgcb_ctl_if;

   logic sleep;                         // Retention sleep
   logic isol_latchen;                  // Isolation latch enable
   logic isol_en_b;                     // Isolation, active low
   logic force_rst_b;                   // Forced partition reset, active low
   logic pok;                           // Power ok
   logic pwrgate_active;                // Flow in progress, combinational from state

   modport fsm (
      output sleep, isol_latchen, isol_en_b, force_rst_b, pok, pwrgate_active
   );

   modport ovr (
      input  sleep, isol_latchen, isol_en_b, force_rst_b, pok, pwrgate_active
   );

endinterface

// File: pgcb_pkg.sv
/*
 * Shared definitions for the power-gate control block
 *   pg_type_t     gating kinds requested by the IP
 *   pgcb_state_t  sequencer states, down flow then up flow
 *   DLY_W, CNT_W  delay code and step counter widths
 *   delay_cycles  maps a delay code to its step length
 */

package pgcb_pkg;

   localparam int DLY_W = 2;            // Width of one cfg_t* delay code
   localparam int CNT_W = 7;            // Step counter, holds up to 64

   // Gating kind, same encoding as ip_pgcb_pg_type
   typedef enum logic [1:0] {
      pg_acc   = 2'b00,                 // IP-accessible
      pg_warm  = 2'b01,                 // Warm reset, handled like inaccessible
      pg_rsvd  = 2'b10,
      pg_inacc = 2'b11                  // IP-inaccessible
   } pg_type_t;

   // Sequencer states
   typedef enum logic [3:0] {
      st_on      = 4'd0,                // Fully powered, idle
      st_pok_dn  = 4'd1,                // pok dropped
      st_isolate = 4'd2,                // Isolation closed
      st_rst_dn  = 4'd3,                // Forced reset asserted
      st_sleep   = 4'd4,                // Retention sleep, single cycle
      st_pmc_req = 4'd5,                // Waiting on PMC ack
      st_off     = 4'd6,                // Gated
      st_pmc_rel = 4'd7,                // Waiting on PMC ack release
      st_wake    = 4'd8,                // Sleep cleared
      st_deisol  = 4'd9,                // Isolation opened
      st_pok_up  = 4'd10                // pok and reset released
   } pgcb_state_t;

   // Code n gives 4^n cycles: 1, 4, 16 or 64
   function automatic logic [CNT_W-1:0] delay_cycles(input logic [DLY_W-1:0] code);
      logic [CNT_W-1:0] one;
      one = 1;
      delay_cycles = one << (2 * code);
   endfunction

endpackage

// File: pgcb_req_sync.sv
/*
 * Request side of the power-gate control block
 * Two-flop synchronizers for the IP request, PMC acknowledge and
 * PMC restore strobes, converted to active-high levels
 * Gating type capture on the first cycle of a synchronized request
 */

`timescale 1ns/1ns

module pgcb_req_sync (
   input  logic       clk,
   input  logic       rst_n,
   input  logic       ip_pgcb_pg_rdy_req_b,   // Async, low requests gating
   input  logic [1:0] ip_pgcb_pg_type,        // Quasi-static alongside the request
   input  logic       pmc_pgcb_pg_ack_b,      // Async PMC ack
   input  logic       pmc_pgcb_restore_b,     // Async PMC restore
   pgcb_req_if.src    req
);

   // Bit order in both stages: 0 request, 1 ack, 2 restore
   logic [2:0] meta_b;                        // First stage, may go metastable
   logic [2:0] sync_b;                        // Second stage, safe to use
   logic       req_rise;                      // Request is about to show up on req

   // Strobes idle high, so both stages come out of reset high
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         meta_b <= '1;
         sync_b <= '1;
      end else begin
         meta_b <= {pmc_pgcb_restore_b, pmc_pgcb_pg_ack_b, ip_pgcb_pg_rdy_req_b};
         sync_b <= meta_b;
      end
   end

   // Falling req_b moving from stage one into stage two
   assign req_rise = !meta_b[0] && sync_b[0];

   // Type is loaded on the same edge req rises, so the FSM sees both together
   // and later changes of the pin do not reach a running flow
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         req.pg_type <= pgcb_pkg::pg_acc;
      end else if (req_rise) begin
         req.pg_type <= pgcb_pkg::pg_type_t'(ip_pgcb_pg_type);
      end
   end

   assign req.req     = ~sync_b[0];           // Active-high views
   assign req.pmc_ack = ~sync_b[1];
   assign req.restore = ~sync_b[2];

endmodule

// File: pgcb_tb.sv
/*
 * Testbench for the power-gate control block
 * PMC model with random ack latency, LCG driven stimulus,
 * edge monitor with a reference model of the gating flow timing,
 * reset, type, restore and DFx override checks
 */

`timescale 1ns/1ns

module pgcb_tb;

   localparam int NUM_FLOWS    = 16;
   localparam int UNGATE_TIMER = 4;
   localparam int NSIG         = 12;            // Monitored bits with outputs at 0..7 and inputs at 8..11

   logic clk = 1'b0;
   logic rst_n;
   logic pmc_pgcb_pg_ack_b;
   logic pmc_pgcb_restore_b;
   logic pmc_pgcb_fet_en_b;
   logic pgcb_pmc_pg_req_b;
   logic [1:0] ip_pgcb_pg_type;
   logic ip_pgcb_pg_rdy_req_b;
   logic ip_pgcb_sleep_en;
   logic pgcb_ip_pg_rdy_ack_b;
   logic pgcb_pok;
   logic pgcb_restore;
   logic pgcb_sleep;
   logic pgcb_isol_latchen;
   logic pgcb_isol_en_b;
   logic pgcb_force_rst_b;
   logic pgcb_pwrgate_active;
   logic pgcb_ip_fet_en_b;
   logic [pgcb_pkg::DLY_W-1:0] cfg_tpokdown, cfg_tisolate, cfg_trstdown;      // Down flow
   logic [pgcb_pkg::DLY_W-1:0] cfg_tsleepinactiv, cfg_tdeisolate, cfg_tpokup; // Up flow
   logic fdfx_pgcb_bypass;
   logic fdfx_pgcb_ovr;
   logic fscan_mode;
   logic fscan_isol_ctrl;
   logic fscan_isol_lat_ctrl;
   logic fscan_ret_ctrl;
   logic [7:0] pgcb_visa;

   int cyc = 0;                                 // Rising edges so far
   int t_rise [NSIG];                           // Cycle of the last rise or -1
   int t_fall [NSIG];
   logic [NSIG-1:0] prev_bits;
   logic [31:0] rng = 32'hd9d7_47c6;            // Stimulus stream
   logic [31:0] pmc_rng = 32'hd9d7_47c6;        // PMC latency stream
   pgcb_pkg::pg_type_t f_type;                  // Type of the flow under test
   logic f_sleep;
   logic f_restore;                             // Flow wakes through PMC restore
   string sig_name [8] = '{"pgcb_pok", "pgcb_isol_en_b", "pgcb_force_rst_b", "pgcb_sleep",
                           "pgcb_pmc_pg_req_b", "pgcb_isol_latchen", "pgcb_ip_pg_rdy_ack_b",
                           "pgcb_restore"};

   pgcb_unit #(.DEF_PWRON(1), .ISOLLATCH_NOSR_EN(0), .UNGATE_TIMER(UNGATE_TIMER)) dut (.*);

   always #4 clk = ~clk;                        // 8 ns period

   always @(posedge clk) cyc <= cyc + 1;

   // Edge monitor runs half a cycle after the driving edge
   always @(negedge clk) begin : edge_mon
      logic [NSIG-1:0] cur;
      cur = {fdfx_pgcb_ovr, pmc_pgcb_restore_b, pmc_pgcb_pg_ack_b, ip_pgcb_pg_rdy_req_b,
             pgcb_restore, pgcb_ip_pg_rdy_ack_b, pgcb_isol_latchen, pgcb_pmc_pg_req_b,
             pgcb_sleep, pgcb_force_rst_b, pgcb_isol_en_b, pgcb_pok};
      for (int i = 0; i < NSIG; i++) begin
         if (cur[i] !== prev_bits[i]) begin
            if (cur[i] === 1'b1) begin
               t_rise[i] = cyc;
            end else begin
               t_fall[i] = cyc;
            end
         end
      end
      prev_bits = cur;
   end

   function automatic logic [31:0] lcg_next(input logic [31:0] s);
      return s * 32'd1664525 + 32'd1013904223;
   endfunction

   function automatic int step_len(input logic [1:0] code);
      return 1 << (2 * code);                   // 1, 4, 16, 64
   endfunction

   // Expected cycle of each output edge in a flow or -1 where the edge must not happen
   // Inputs reach the FSM 3 edges after they are driven; pok, isolation,
   // reset and sleep pins trail the FSM by one more edge
   function automatic int expected_flow(input int sig, input logic rise);
      int p_pok, p_isol, p_rst, p_req;
      int wake, u_slp, u_isol, u_pok, u_ack;
      logic acc;
      logic latch;
      acc    = (f_type == pgcb_pkg::pg_acc);
      latch  = (f_type == pgcb_pkg::pg_inacc) || (f_type == pgcb_pkg::pg_warm);
      p_pok  = t_fall[8] + 4;                   // Request driven low
      p_isol = p_pok + step_len(cfg_tpokdown);
      p_rst  = p_isol + step_len(cfg_tisolate);
      p_req  = p_rst + (acc ? 1 : step_len(cfg_trstdown));  // Sleep and PMC request
      // Restore goes low one cycle ahead of the request release and wins
      wake   = f_restore ? t_fall[10] + 3 : t_rise[8] + 3;
      u_slp  = t_rise[9] + 4;                   // PMC ack released
      u_isol = u_slp + step_len(cfg_tsleepinactiv);
      u_pok  = u_isol + step_len(cfg_tdeisolate);
      u_ack  = u_pok + step_len(cfg_tpokup) - 1;  // Ack pin is not behind the override stage
      case (sig)
         0: return rise ? u_pok : p_pok;
         1: return rise ? u_isol : p_isol;
         2: return acc ? -1 : (rise ? u_pok : p_rst);
         3: return !f_sleep ? -1 : (rise ? p_req : u_slp);
         4: return rise ? wake : p_req;
         5: return !latch ? -1 : (rise ? p_isol : u_isol);
         6: return rise ? u_ack : t_fall[9] + 3;
         default: return !f_restore ? -1 : (rise ? wake : u_ack);
      endcase
   endfunction

   task automatic abort_run();
      $display("Finished with errors");
      $fatal(1, "Stopped at the first failing check");
   endtask

   task automatic check_bit(input string name, input logic exp, input logic got);
      if (got !== exp) begin
         $display("Error at %0t ns: %s expected %b got %b", $time, name, exp, got);
         abort_run();
      end
   endtask

   task automatic check_state(input pgcb_pkg::pgcb_state_t exp);
      pgcb_pkg::pgcb_state_t got;
      got = pgcb_pkg::pgcb_state_t'(pgcb_visa[3:0]);
      if (got !== exp) begin
         $display("Error at %0t ns: pgcb_visa state expected %s got %s",
                  $time, exp.name(), got.name());
         abort_run();
      end
   endtask

   task automatic check_cycle(input string name, input int exp, input int got);
      if (got != exp) begin
         $display("Error at %0t ns: %s edge cycle expected %0d got %0d", $time, name, exp, got);
         abort_run();
      end
   endtask

   task automatic clear_times();
      for (int i = 0; i < NSIG; i++) begin
         t_rise[i] = -1;
         t_fall[i] = -1;
      end
   endtask

   // PMC model copies pg_req_b onto ack_b after 1 to 20 cycles
   initial begin : pmc_model
      int wait_cyc;
      forever begin
         @(posedge clk);
         if (rst_n && (pgcb_pmc_pg_req_b != pmc_pgcb_pg_ack_b)) begin
            pmc_rng  = lcg_next(pmc_rng);
            wait_cyc = pmc_rng[31:16] % 20 + 1;
            repeat (wait_cyc - 1) @(posedge clk);
            pmc_pgcb_pg_ack_b <= pgcb_pmc_pg_req_b;
         end
      end
   end

   // Longest flow with every step at 64 stays well under 600 cycles
   initial begin : watchdog
      repeat ((NUM_FLOWS + 4) * 600) @(posedge clk);
      $display("Timeout: the DUT did not complete the test sequence in time");
      abort_run();
   end

   initial begin : stim
      int hold;
      rst_n                = 1'b0;
      ip_pgcb_pg_rdy_req_b = 1'b1;              // Idle and powered
      ip_pgcb_pg_type      = 2'b00;
      ip_pgcb_sleep_en     = 1'b0;
      pmc_pgcb_pg_ack_b    = 1'b1;
      pmc_pgcb_restore_b   = 1'b1;
      pmc_pgcb_fet_en_b    = 1'b0;
      {cfg_tpokdown, cfg_tisolate, cfg_trstdown} = '0;
      {cfg_tsleepinactiv, cfg_tdeisolate, cfg_tpokup} = '0;
      fdfx_pgcb_bypass     = 1'b0;
      fdfx_pgcb_ovr        = 1'b0;
      fscan_mode           = 1'b0;
      fscan_isol_ctrl      = 1'b0;
      fscan_isol_lat_ctrl  = 1'b0;
      fscan_ret_ctrl       = 1'b0;
      repeat (10) @(posedge clk);
      rst_n <= 1'b1;
      repeat (2) @(posedge clk);

      check_bit("pgcb_pok", 1'b1, pgcb_pok);
      check_bit("pgcb_sleep", 1'b0, pgcb_sleep);
      check_bit("pgcb_isol_en_b", 1'b1, pgcb_isol_en_b);
      check_bit("pgcb_isol_latchen", 1'b0, pgcb_isol_latchen);
      check_bit("pgcb_force_rst_b", 1'b1, pgcb_force_rst_b);
      check_bit("pgcb_pmc_pg_req_b", 1'b1, pgcb_pmc_pg_req_b);
      check_bit("pgcb_ip_pg_rdy_ack_b", 1'b1, pgcb_ip_pg_rdy_ack_b);
      check_bit("pgcb_restore", 1'b0, pgcb_restore);
      check_bit("pgcb_pwrgate_active", 1'b0, pgcb_pwrgate_active);
      check_state(pgcb_pkg::st_on);

      for (int n = 0; n < NUM_FLOWS; n++) begin
         rng       = lcg_next(rng);
         f_type    = pgcb_pkg::pg_type_t'(rng[31:30]);
         f_sleep   = rng[29];
         f_restore = rng[28];
         hold      = rng[27:24] + 2;            // Cycles spent gated
         cfg_tpokdown      <= rng[23:22];
         cfg_tisolate      <= rng[21:20];
         cfg_trstdown      <= rng[19:18];
         cfg_tsleepinactiv <= rng[17:16];
         cfg_tdeisolate    <= rng[15:14];
         cfg_tpokup        <= rng[13:12];
         ip_pgcb_pg_type   <= rng[31:30];
         ip_pgcb_sleep_en  <= rng[29];
         @(posedge clk);
         clear_times();
         ip_pgcb_pg_rdy_req_b <= 1'b0;
         while (pgcb_pok !== 1'b0) @(posedge clk);
         rng = lcg_next(rng);
         ip_pgcb_pg_type <= rng[31:30];         // Must not reach the running flow
         while (pgcb_ip_pg_rdy_ack_b !== 1'b0) @(posedge clk);

         check_state(pgcb_pkg::st_off);
         check_bit("pgcb_pwrgate_active", 1'b1, pgcb_pwrgate_active);
         check_bit("pgcb_force_rst_b", f_type == pgcb_pkg::pg_acc, pgcb_force_rst_b);
         check_bit("pgcb_isol_latchen",
                   (f_type == pgcb_pkg::pg_inacc) || (f_type == pgcb_pkg::pg_warm),
                   pgcb_isol_latchen);
         check_bit("pgcb_sleep", f_sleep, pgcb_sleep);
         check_bit("pgcb_visa req", 1'b1, pgcb_visa[4]);
         check_bit("pgcb_visa pmc_ack", 1'b1, pgcb_visa[5]);
         repeat (hold) @(posedge clk);
         if (f_restore) begin
            pmc_pgcb_restore_b <= 1'b0;         // PMC wakes the partition on its own
            @(posedge clk);
         end
         ip_pgcb_pg_rdy_req_b <= 1'b1;
         while (pgcb_ip_pg_rdy_ack_b !== 1'b1) @(posedge clk);
         check_state(pgcb_pkg::st_on);
         check_bit("pgcb_visa restore", f_restore, pgcb_visa[6]);
         check_bit("pgcb_visa pmc_ack", 1'b0, pgcb_visa[5]);
         pmc_pgcb_restore_b <= 1'b1;
         for (int s = 0; s < 8; s++) begin
            check_cycle({sig_name[s], " fall"}, expected_flow(s, 1'b0), t_fall[s]);
            check_cycle({sig_name[s], " rise"}, expected_flow(s, 1'b1), t_rise[s]);
         end
      end

      // Scan overrides sleep and isolation directly
      fscan_mode <= 1'b1;
      for (int k = 0; k < 4; k++) begin
         rng = lcg_next(rng);
         fscan_ret_ctrl      <= rng[31];
         fscan_isol_ctrl     <= rng[30];
         fscan_isol_lat_ctrl <= rng[29];
         @(posedge clk);
         check_bit("pgcb_sleep", rng[31], pgcb_sleep);
         check_bit("pgcb_isol_en_b", rng[30], pgcb_isol_en_b);
         check_bit("pgcb_isol_latchen", rng[29], pgcb_isol_latchen);
      end
      fscan_mode <= 1'b0;

      pmc_pgcb_fet_en_b <= 1'b1;                // FET follows the PMC one register late
      repeat (2) @(posedge clk);
      check_bit("pgcb_ip_fet_en_b", 1'b1, pgcb_ip_fet_en_b);
      pmc_pgcb_fet_en_b <= 1'b0;
      repeat (2) @(posedge clk);
      check_bit("pgcb_ip_fet_en_b", 1'b0, pgcb_ip_fet_en_b);

      fdfx_pgcb_bypass <= 1'b1;                 // Bypass with gated values
      repeat (2) @(posedge clk);
      check_bit("pgcb_visa bypass", 1'b1, pgcb_visa[7]);
      check_bit("pgcb_pok", 1'b0, pgcb_pok);
      check_bit("pgcb_sleep", 1'b1, pgcb_sleep);
      check_bit("pgcb_isol_en_b", 1'b0, pgcb_isol_en_b);
      check_bit("pgcb_isol_latchen", 1'b1, pgcb_isol_latchen);
      check_bit("pgcb_force_rst_b", 1'b0, pgcb_force_rst_b);
      check_bit("pgcb_ip_fet_en_b", 1'b1, pgcb_ip_fet_en_b);

      clear_times();
      fdfx_pgcb_ovr <= 1'b1;                    // Bypass powers up
      while (pgcb_pok !== 1'b1) @(posedge clk);
      // Counter starts one edge after the command and the pok register adds one more
      check_cycle("pgcb_pok rise", t_rise[11] + UNGATE_TIMER + 1, t_rise[0]);
      check_bit("pgcb_ip_fet_en_b", 1'b0, pgcb_ip_fet_en_b);
      check_bit("pgcb_sleep", 1'b0, pgcb_sleep);
      check_bit("pgcb_isol_en_b", 1'b1, pgcb_isol_en_b);
      check_bit("pgcb_force_rst_b", 1'b1, pgcb_force_rst_b);

      fdfx_pgcb_ovr <= 1'b0;                    // Gated again before bypass ends
      repeat (2) @(posedge clk);
      check_bit("pgcb_pok", 1'b0, pgcb_pok);
      check_bit("pgcb_isol_en_b", 1'b0, pgcb_isol_en_b);

      fdfx_pgcb_bypass <= 1'b0;                 // Pins return to the powered FSM values
      repeat (2) @(posedge clk);
      check_bit("pgcb_pok", 1'b1, pgcb_pok);
      check_bit("pgcb_isol_en_b", 1'b1, pgcb_isol_en_b);
      check_bit("pgcb_pwrgate_active", 1'b0, pgcb_pwrgate_active);
      check_state(pgcb_pkg::st_on);
      $display("Finished with no errors");
      $finish;
   end

endmodule

// File: pgcb_unit.sv
/*
 * Top level of the power-gate control block
 * Request synchronizer, sequencer FSM and DFx override stage,
 * joined by the request and control bundles
 * pgcb_visa: state, then req, pmc_ack, restore and bypass
 */

`timescale 1ns/1ns

module pgcb_unit #(
   parameter int DEF_PWRON         = 1,
   parameter int ISOLLATCH_NOSR_EN = 0,
   parameter int UNGATE_TIMER      = 4
) (
   input  logic                       clk,
   input  logic                       rst_n,
   // PMC side
   output logic                       pgcb_pmc_pg_req_b,
   input  logic                       pmc_pgcb_pg_ack_b,
   input  logic                       pmc_pgcb_restore_b,
   input  logic                       pmc_pgcb_fet_en_b,
   // IP side
   input  logic [1:0]                 ip_pgcb_pg_type,
   input  logic                       ip_pgcb_pg_rdy_req_b,
   output logic                       pgcb_ip_pg_rdy_ack_b,
   output logic                       pgcb_pok,
   output logic                       pgcb_restore,
   output logic                       pgcb_sleep,
   output logic                       pgcb_isol_latchen,
   output logic                       pgcb_isol_en_b,
   output logic                       pgcb_force_rst_b,
   output logic                       pgcb_pwrgate_active,
   output logic                       pgcb_ip_fet_en_b,
   // Configuration
   input  logic                       ip_pgcb_sleep_en,
   input  logic [pgcb_pkg::DLY_W-1:0] cfg_tpokdown,
   input  logic [pgcb_pkg::DLY_W-1:0] cfg_tisolate,
   input  logic [pgcb_pkg::DLY_W-1:0] cfg_trstdown,
   input  logic [pgcb_pkg::DLY_W-1:0] cfg_tsleepinactiv,
   input  logic [pgcb_pkg::DLY_W-1:0] cfg_tdeisolate,
   input  logic [pgcb_pkg::DLY_W-1:0] cfg_tpokup,
   // DFx
   input  logic                       fdfx_pgcb_bypass,
   input  logic                       fdfx_pgcb_ovr,
   input  logic                       fscan_mode,
   input  logic                       fscan_isol_ctrl,
   input  logic                       fscan_isol_lat_ctrl,
   input  logic                       fscan_ret_ctrl,
   output logic [7:0]                 pgcb_visa
);

   pgcb_pkg::pgcb_state_t fsm_state;

   pgcb_req_if req_if ();
   pgcb_ctl_if ctl_if ();

   assign pgcb_visa = {fdfx_pgcb_bypass, req_if.restore, req_if.pmc_ack, req_if.req, fsm_state};

   pgcb_req_sync i_pgcb_req_sync (
      .clk, .rst_n, .ip_pgcb_pg_rdy_req_b, .ip_pgcb_pg_type,
      .pmc_pgcb_pg_ack_b, .pmc_pgcb_restore_b,
      .req (req_if.src)
   );

   pgcb_fsm #(
      .DEF_PWRON         (DEF_PWRON),
      .ISOLLATCH_NOSR_EN (ISOLLATCH_NOSR_EN)
   ) i_pgcb_fsm (
      .clk, .rst_n, .ip_pgcb_sleep_en,
      .cfg_tpokdown, .cfg_tisolate, .cfg_trstdown,
      .cfg_tsleepinactiv, .cfg_tdeisolate, .cfg_tpokup,
      .req                  (req_if.dst),
      .ctl                  (ctl_if.fsm),
      .pgcb_pmc_pg_req_b, .pgcb_ip_pg_rdy_ack_b, .pgcb_restore,
      .state                (fsm_state)
   );

   pgcb_dfx_ovr #(
      .UNGATE_TIMER (UNGATE_TIMER)
   ) i_pgcb_dfx_ovr (
      .clk, .rst_n, .fdfx_pgcb_bypass, .fdfx_pgcb_ovr,
      .fscan_mode, .fscan_isol_ctrl, .fscan_isol_lat_ctrl, .fscan_ret_ctrl,
      .pmc_pgcb_fet_en_b,
      .ctl (ctl_if.ovr),
      .pgcb_sleep, .pgcb_isol_latchen, .pgcb_isol_en_b, .pgcb_force_rst_b,
      .pgcb_pok, .pgcb_pwrgate_active, .pgcb_ip_fet_en_b
   );

endmodule

// File: run.sh
#!/bin/sh
# Build the testbench with Verilator, run it, and judge the run from its log
rm -rf obj_dir sim.log
verilator --binary --timing -Wno-fatal -f all.f --top-module pgcb_tb -o pgcb_sim &&
obj_dir/pgcb_sim > sim.log 2>&1 ||
{ cat sim.log 2>/dev/null; echo "Build or simulation failed"; exit 1; }
cat sim.log
grep -q "^Finished with no errors$" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }
